/* common/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address width
`define CACHE_ADDR_W 32

// width of one response word
`define CACHE_WORD_W 64

// sets in each way
`define CACHE_SETS 64

// associativity
`define CACHE_WAYS 2

// words in one cache line
`define CACHE_LINE_WORDS 4

// nonzero start value of the replacement lfsr
`define CACHE_LFSR_SEED 16'hACE1

`endif

/* common/cachePkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cachePkg;

  // address field widths
  localparam int BYTE_BITS = $clog2(`CACHE_WORD_W / 8);
  localparam int OFFS_BITS = $clog2(`CACHE_LINE_WORDS);
  localparam int IDX_BITS  = $clog2(`CACHE_SETS);
  localparam int TAG_BITS  = `CACHE_ADDR_W - IDX_BITS - OFFS_BITS - BYTE_BITS;
  localparam int LINE_BITS = BYTE_BITS + OFFS_BITS;

  typedef logic [`CACHE_ADDR_W-1:0] addrT;
  typedef logic [TAG_BITS-1:0]      tagT;
  typedef logic [IDX_BITS-1:0]      indexT;
  typedef logic [OFFS_BITS-1:0]     offsetT;
  typedef logic [`CACHE_WORD_W-1:0] wordT;
  // word 0 sits in the low bits
  typedef wordT [`CACHE_LINE_WORDS-1:0] lineT;
  typedef logic [`CACHE_WAYS-1:0]   wayMaskT;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    COMPARE,
    FETCH,
    FILL,
    RESP
  } ctrlStateT;

  function automatic tagT tagOf(addrT addr);
    return addr[`CACHE_ADDR_W-1 -: TAG_BITS];
  endfunction

  function automatic indexT indexOf(addrT addr);
    return addr[LINE_BITS +: IDX_BITS];
  endfunction

  function automatic offsetT offsetOf(addrT addr);
    return addr[BYTE_BITS +: OFFS_BITS];
  endfunction

endpackage

`default_nettype wire

/* cache/cacheWay.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cacheWay (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              lookupEn_i,
  input  cachePkg::indexT  lookupIndex_i,
  input  cachePkg::tagT    cmpTag_i,
  input  wire              fillEn_i,
  input  cachePkg::indexT  fillIndex_i,
  input  cachePkg::tagT    fillTag_i,
  input  cachePkg::lineT   fillLine_i,
  output logic             wayHit_o,
  output logic             wayValid_o,
  output cachePkg::lineT   wayLine_o
);

  import cachePkg::*;

  logic [`CACHE_SETS-1:0] validBits;
  tagT                    tagArray [`CACHE_SETS];
  lineT                   lineArray [`CACHE_SETS];

  logic rdValid;
  tagT  rdTag;
  lineT rdLine;

  // one valid bit per set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
    end else if (fillEn_i) begin
      validBits[fillIndex_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArray[fillIndex_i]  <= fillTag_i;
      lineArray[fillIndex_i] <= fillLine_i;
    end
  end

  // lookup result is registered and visible one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdValid <= 1'b0;
    end else if (lookupEn_i) begin
      rdValid <= validBits[lookupIndex_i];
    end
  end

  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      rdTag  <= tagArray[lookupIndex_i];
      rdLine <= lineArray[lookupIndex_i];
    end
  end

  // tag compare against the latched request
  assign wayHit_o   = rdValid && (rdTag == cmpTag_i);
  assign wayValid_o = rdValid;
  assign wayLine_o  = rdLine;

endmodule

`default_nettype wire

/* cache/hitSelect.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_cfg.svh"

module hitSelect (
  input  wire               clk,
  input  wire               rst_n,
  input  cachePkg::wayMaskT wayHit_i,
  input  cachePkg::lineT    wayLine_i [`CACHE_WAYS],
  input  cachePkg::offsetT  wordSel_i,
  input  wire               respLoad_i,
  output logic              anyHit_o,
  output cachePkg::wordT    respData_o
);

  import cachePkg::*;

  lineT hitLine;
  wordT hitWord;

  assign anyHit_o = |wayHit_i;

  // at most one way hits, so an or-style mux is enough
  always_comb begin
    hitLine = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (wayHit_i[w]) begin
        hitLine = wayLine_i[w];
      end
    end
  end

  assign hitWord = hitLine[wordSel_i];

  // response holds until the next load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      respData_o <= '0;
    end else if (respLoad_i) begin
      respData_o <= hitWord;
    end
  end

endmodule

`default_nettype wire

/* cache/cacheCtrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cacheCtrl (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               reqValid_i,
  input  cachePkg::addrT    reqAddr_i,
  output logic              reqReady_o,
  input  wire               respReady_i,
  input  wire               anyHit_i,
  input  cachePkg::wayMaskT wayValid_i,
  output logic              lookupEn_o,
  output cachePkg::indexT   lookupIndex_o,
  output cachePkg::tagT     cmpTag_o,
  output cachePkg::offsetT  wordSel_o,
  output cachePkg::wayMaskT fillEn_o,
  output cachePkg::indexT   fillIndex_o,
  output cachePkg::tagT     fillTag_o,
  output logic              respLoad_o,
  output logic              respValid_o,
  output logic              fetchStart_o,
  output cachePkg::addrT    fetchAddr_o,
  input  wire               fetchDone_i
);

  import cachePkg::*;

  localparam int WAY_BITS = (`CACHE_WAYS > 1) ? $clog2(`CACHE_WAYS) : 1;

  ctrlStateT state;
  ctrlStateT stateNext;
  addrT      reqAddr;
  wayMaskT   victim;
  wayMaskT   victimNext;
  logic [15:0] lfsr;
  logic        accept;
  logic        missDetect;

  assign accept     = reqValid_i && reqReady_o;
  assign missDetect = (state == COMPARE) && !anyHit_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      IDLE:    if (accept) stateNext = LOOKUP;
      LOOKUP:  stateNext = COMPARE;
      COMPARE: stateNext = anyHit_i ? RESP : FETCH;
      FETCH:   if (fetchDone_i) stateNext = FILL;
      // refilled line is looked up again and then hits
      FILL:    stateNext = LOOKUP;
      RESP:    if (respReady_i) stateNext = IDLE;
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= reqAddr_i;
    end
  end

  // x^16 + x^14 + x^13 + x^11 polynomial stepping every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= `CACHE_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end
  end

  // lowest invalid way first, random way otherwise
  always_comb begin
    victimNext = '0;
    victimNext[lfsr[WAY_BITS-1:0]] = 1'b1;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!wayValid_i[w]) begin
        victimNext    = '0;
        victimNext[w] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victim <= '0;
    end else if (missDetect) begin
      victim <= victimNext;
    end
  end

  assign reqReady_o    = (state == IDLE);
  assign lookupEn_o    = (state == LOOKUP);
  assign lookupIndex_o = indexOf(reqAddr);
  assign cmpTag_o      = tagOf(reqAddr);
  assign wordSel_o     = offsetOf(reqAddr);

  assign fillEn_o    = (state == FILL) ? victim : '0;
  assign fillIndex_o = indexOf(reqAddr);
  assign fillTag_o   = tagOf(reqAddr);

  assign respLoad_o  = (state == COMPARE) && anyHit_i;
  assign respValid_o = (state == RESP);

  // line aligned base for the refill
  assign fetchStart_o = missDetect;
  assign fetchAddr_o  = {tagOf(reqAddr), indexOf(reqAddr), {LINE_BITS{1'b0}}};

endmodule

`default_nettype wire

/* logic/axiLineFetch.sv */
`default_nettype none
`timescale 1ns/1ps

module axiLineFetch (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             fetchStart_i,
  input  cachePkg::addrT  fetchAddr_i,
  output logic            fetchDone_o,
  output cachePkg::lineT  fetchLine_o,
  output logic            arValid_o,
  output cachePkg::addrT  arAddr_o,
  output logic [2:0]      arProt_o,
  input  wire             arReady_i,
  input  wire             rValid_i,
  input  cachePkg::wordT  rData_i,
  // error responses are ignored and the data is taken as is
  input  wire [1:0]       rResp_i,
  output logic            rReady_o
);

  import cachePkg::*;

  addrT   baseAddr;
  offsetT beat;
  logic   arDone;
  logic   rDone;

  assign arDone = arValid_o && arReady_i;
  assign rDone  = rValid_i && rReady_o;

  // one outstanding beat with the address phase before the data phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arValid_o   <= 1'b0;
      rReady_o    <= 1'b0;
      beat        <= '0;
      fetchDone_o <= 1'b0;
    end else begin
      fetchDone_o <= 1'b0;
      if (fetchStart_i) begin
        beat      <= '0;
        arValid_o <= 1'b1;
      end else if (arDone) begin
        arValid_o <= 1'b0;
        rReady_o  <= 1'b1;
      end else if (rDone) begin
        rReady_o <= 1'b0;
        if (beat == '1) begin
          fetchDone_o <= 1'b1;
        end else begin
          beat      <= beat + 1'b1;
          arValid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetchStart_i) begin
      baseAddr <= fetchAddr_i;
    end
  end

  // each word lands in its own slot
  always_ff @(posedge clk) begin
    if (rDone) begin
      fetchLine_o[beat] <= rData_i;
    end
  end

  assign arAddr_o = baseAddr + (addrT'(beat) << BYTE_BITS);
  assign arProt_o = 3'b000;

endmodule

`default_nettype wire

/* cache/cacheTop.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cacheTop (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             reqValid_i,
  input  cachePkg::addrT  reqAddr_i,
  output logic            reqReady_o,
  output logic            respValid_o,
  output cachePkg::wordT  respData_o,
  input  wire             respReady_i,
  output logic            arValid_o,
  output cachePkg::addrT  arAddr_o,
  output logic [2:0]      arProt_o,
  input  wire             arReady_i,
  input  wire             rValid_i,
  input  cachePkg::wordT  rData_i,
  input  wire [1:0]       rResp_i,
  output logic            rReady_o
);

  import cachePkg::*;

  logic    anyHit;
  wayMaskT wayHit;
  wayMaskT wayValid;
  lineT    wayLine [`CACHE_WAYS];
  logic    lookupEn;
  indexT   lookupIndex;
  tagT     cmpTag;
  offsetT  wordSel;
  wayMaskT fillEn;
  indexT   fillIndex;
  tagT     fillTag;
  lineT    fetchLine;
  logic    respLoad;
  logic    fetchStart;
  addrT    fetchAddr;
  logic    fetchDone;

  cacheCtrl uCtrl (
    .clk, .rst_n,
    .reqValid_i, .reqAddr_i, .reqReady_o,
    .respReady_i, .anyHit_i(anyHit), .wayValid_i(wayValid),
    .lookupEn_o(lookupEn), .lookupIndex_o(lookupIndex), .cmpTag_o(cmpTag),
    .wordSel_o(wordSel), .fillEn_o(fillEn), .fillIndex_o(fillIndex),
    .fillTag_o(fillTag), .respLoad_o(respLoad), .respValid_o,
    .fetchStart_o(fetchStart), .fetchAddr_o(fetchAddr), .fetchDone_i(fetchDone)
  );

  for (genvar g = 0; g < `CACHE_WAYS; g++) begin : gWay
    cacheWay uWay (
      .clk, .rst_n,
      .lookupEn_i(lookupEn), .lookupIndex_i(lookupIndex), .cmpTag_i(cmpTag),
      .fillEn_i(fillEn[g]), .fillIndex_i(fillIndex), .fillTag_i(fillTag),
      .fillLine_i(fetchLine),
      .wayHit_o(wayHit[g]), .wayValid_o(wayValid[g]), .wayLine_o(wayLine[g])
    );
  end

  hitSelect uHitSel (
    .clk, .rst_n,
    .wayHit_i(wayHit), .wayLine_i(wayLine), .wordSel_i(wordSel),
    .respLoad_i(respLoad), .anyHit_o(anyHit), .respData_o
  );

  axiLineFetch uFetch (
    .clk, .rst_n,
    .fetchStart_i(fetchStart), .fetchAddr_i(fetchAddr),
    .fetchDone_o(fetchDone), .fetchLine_o(fetchLine),
    .arValid_o, .arAddr_o, .arProt_o, .arReady_i,
    .rValid_i, .rData_i, .rResp_i, .rReady_o
  );

endmodule

`default_nettype wire

/* sim/mem_pattern.svh */
`ifndef MEM_PATTERN_SVH
`define MEM_PATTERN_SVH

// memory word at byte address a as a fixed mix of its bits
`define MEM_WORD(a) {((a) * 32'h9E3779B1) ^ 32'hC3A5F00F, (a) ^ ((a) << 7) ^ 32'h5A5AC3C3}

`endif

/* sim/axiMemModel.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_pattern.svh"

module axiMemModel (
  input  wire             clk,
  input  wire             rst_n,
  // one random draw per cycle from the testbench
  input  wire [2:0]       randBits_i,
  input  wire             arValid_i,
  input  cachePkg::addrT  arAddr_i,
  output logic            arReady_o,
  output logic            rValid_o,
  output cachePkg::wordT  rData_o,
  output logic [1:0]      rResp_o,
  input  wire             rReady_i
);

  import cachePkg::*;

  addrT addrQ;
  logic pending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arReady_o <= 1'b0;
      rValid_o  <= 1'b0;
      rData_o   <= '0;
      rResp_o   <= 2'b00;
      addrQ     <= '0;
      pending   <= 1'b0;
    end else begin
      // one address at a time while ready toggles at random
      if (arValid_i && arReady_o) begin
        addrQ     <= arAddr_i;
        pending   <= 1'b1;
        arReady_o <= 1'b0;
      end else begin
        arReady_o <= !pending && !rValid_o && randBits_i[0];
      end
      // data comes after a random gap and stays until taken
      if (pending && !rValid_o && randBits_i[1]) begin
        rValid_o <= 1'b1;
        rData_o  <= `MEM_WORD(addrQ);
        // slverr now and then which the cache ignores
        rResp_o  <= {randBits_i[2], 1'b0};
        pending  <= 1'b0;
      end else if (rValid_o && rReady_i) begin
        rValid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_cache.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_pattern.svh"

module tb_cache;

  import cachePkg::*;

  localparam int NUM_REQ   = 300;
  localparam int TIMEOUT   = 200;
  localparam int HIT_EDGES = 2;
  localparam logic [31:0] SEED = 32'h838085b3;

  logic        clk;
  logic        rst_n;
  logic        reqValid;
  addrT        reqAddr;
  logic        reqReady;
  logic        respValid;
  wordT        respData;
  logic        respReady;
  logic        arValid;
  addrT        arAddr;
  logic [2:0]  arProt;
  logic        arReady;
  logic        rValid;
  wordT        rData;
  logic [1:0]  rResp;
  logic        rReady;
  logic [2:0]  stallBits;
  logic [31:0] stimState;
  logic [31:0] stallState;

  addrT arLog [$];
  bit   seenLine [addrT];
  int   tagsInSet [int];
  addrT prevBase;
  int   reqCount;
  int   hits;
  int   misses;
  int   refills;
  int   n;

  // set 21 gets three tags and keeps evicting while the others get two
  tagT   tagPool [3] = '{21'h00001, 21'h0ABCD, 21'h1F00F};
  indexT setPool [3] = '{6'd0, 6'd21, 6'd63};

  cacheTop uut (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqAddr_i(reqAddr), .reqReady_o(reqReady),
    .respValid_o(respValid), .respData_o(respData), .respReady_i(respReady),
    .arValid_o(arValid), .arAddr_o(arAddr), .arProt_o(arProt), .arReady_i(arReady),
    .rValid_i(rValid), .rData_i(rData), .rResp_i(rResp), .rReady_o(rReady)
  );

  axiMemModel uMem (
    .clk(clk), .rst_n(rst_n), .randBits_i(stallBits),
    .arValid_i(arValid), .arAddr_i(arAddr), .arReady_o(arReady),
    .rValid_o(rValid), .rData_o(rData), .rResp_o(rResp), .rReady_i(rReady)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abortRun();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportTimeout(input string what);
    $display("timeout: %s", what);
    abortRun();
  endtask

  task automatic checkWord(input string name, input wordT expv, input wordT act);
    if (act !== expv) begin
      $display("ERROR %s: expected %h, actual %h", name, expv, act);
      abortRun();
    end
  endtask

  task automatic checkAddr(input string name, input addrT expv, input addrT act);
    if (act !== expv) begin
      $display("ERROR %s: expected %h, actual %h", name, expv, act);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic expv, input logic act);
    if (act !== expv) begin
      $display("ERROR %s: expected %b, actual %b", name, expv, act);
      abortRun();
    end
  endtask

  task automatic checkProt(input string name, input logic [2:0] expv,
                           input logic [2:0] act);
    if (act !== expv) begin
      $display("ERROR %s: expected %h, actual %h", name, expv, act);
      abortRun();
    end
  endtask

  task automatic checkCount(input string name, input int expv, input int act);
    if (act != expv) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expv, act);
      abortRun();
    end
  endtask

  // memory stall pattern from a generator of its own
  always @(posedge clk) begin
    #1;
    stallState = xorshift32(stallState);
    stallBits  = stallState[2:0];
  end

  // AR beats seen on the bus
  always @(posedge clk) begin
    if (rst_n && arValid && arReady) begin
      checkProt("arProt", 3'b000, arProt);
      arLog.push_back(arAddr);
    end
  end

  function automatic addrT nextAddr();
    logic [31:0] r;
    int          s;
    int          t;
    stimState = xorshift32(stimState);
    r = stimState;
    s = r[7:0] % 3;
    t = (s == 1) ? r[15:8] % 3 : r[15:8] % 2;
    // now and then go back to the line just used
    if (r[18:16] == 3'd0 && reqCount > 0) begin
      return prevBase | addrT'(r[23:19]);
    end
    return {tagPool[t], setPool[s], r[23:19]};
  endfunction

  task automatic runRequest(input addrT addr);
    addrT base;
    wordT expWord;
    int   idx;
    int   edges;
    int   hold;
    int   beats;
    int   i;
    bit   accepted;
    bit   gotResp;
    bit   seen;
    bit   mustHit;
    base    = addr & ~addrT'(31);
    expWord = `MEM_WORD(addr & ~addrT'(7));
    idx  = addr[10:5];
    seen = seenLine.exists(base);
    // with at most two tags in a set nothing is ever evicted
    mustHit = seen && (base == prevBase || tagsInSet[idx] <= 2);
    arLog.delete();
    reqAddr  = addr;
    reqValid = 1'b1;
    accepted = 1'b0;
    i = 0;
    while (!accepted && i < TIMEOUT) begin
      @(posedge clk);
      accepted = reqReady;
      i++;
    end
    if (!accepted) reportTimeout("request was never accepted");
    #1;
    reqValid = 1'b0;
    reqAddr  = '0;
    edges   = 0;
    gotResp = 1'b0;
    while (!gotResp && edges < TIMEOUT) begin
      @(posedge clk);
      edges++;
      gotResp = respValid;
      checkFlag("reqReady while busy", 1'b0, reqReady);
    end
    if (!gotResp) reportTimeout("no response after an accepted request");
    checkWord("read data", expWord, respData);
    stimState = xorshift32(stimState);
    hold = stimState % 5;
    for (i = 0; i < hold; i++) begin
      @(posedge clk);
      checkFlag("respValid under back-pressure", 1'b1, respValid);
      checkWord("respData under back-pressure", expWord, respData);
      checkFlag("reqReady under back-pressure", 1'b0, reqReady);
    end
    #1;
    respReady = 1'b1;
    @(posedge clk);
    checkFlag("respValid at handshake", 1'b1, respValid);
    #1;
    respReady = 1'b0;
    beats = arLog.size();
    if (!seen) checkCount("AR beats on first access", 4, beats);
    if (mustHit) checkCount("AR beats on resident line", 0, beats);
    if (beats == 0) begin
      // respValid rose one edge before it was first seen
      checkCount("hit latency", HIT_EDGES, edges - 1);
      hits++;
    end else begin
      checkCount("AR beats on miss", 4, beats);
      for (i = 0; i < 4; i++) begin
        checkAddr("AR address", base + addrT'(8 * i), arLog[i]);
      end
      misses++;
      if (seen) refills++;
    end
    if (!seen) begin
      seenLine[base] = 1'b1;
      if (tagsInSet.exists(idx)) tagsInSet[idx]++;
      else tagsInSet[idx] = 1;
    end
    prevBase = base;
    reqCount++;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    reqValid   = 1'b0;
    reqAddr    = '0;
    respReady  = 1'b0;
    stallBits  = 3'b000;
    stimState  = SEED;
    stallState = ~SEED;
    prevBase   = '0;
    reqCount   = 0;
    hits       = 0;
    misses     = 0;
    refills    = 0;
    for (n = 0; n < 8; n++) begin
      @(posedge clk);
      #1;
      checkFlag("respValid in reset", 1'b0, respValid);
      checkFlag("arValid in reset", 1'b0, arValid);
      checkFlag("rReady in reset", 1'b0, rReady);
      checkFlag("reqReady in reset", 1'b1, reqReady);
    end
    rst_n = 1'b1;
    @(posedge clk);
    checkFlag("reqReady after reset", 1'b1, reqReady);
    checkFlag("respValid after reset", 1'b0, respValid);
    #1;
    for (n = 0; n < NUM_REQ; n++) begin
      runRequest(nextAddr());
    end
    if (hits > 0 && misses > 0 && refills > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("stimulus never produced a hit, a miss and a refill after eviction");
      abortRun();
    end
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
+incdir+sim
common/cachePkg.sv
cache/cacheWay.sv
cache/hitSelect.sv
cache/cacheCtrl.sv
logic/axiLineFetch.sv
cache/cacheTop.sv
sim/axiMemModel.sv
sim/tb_cache.sv
